//--- rtl/sf_ops.svh
// register map: r0..r5 = m0..m5, r6..r9 = k0..k3, r10..r13 = a b c d
// mux lags the fetch by one edge, so entry n loads sample n
7'd0:  inst_o <= sf_inst(OP_LOAD, 4'd0, 4'd0, 4'd0);      // m0
7'd1:  inst_o <= sf_inst(OP_LOAD, 4'd1, 4'd0, 4'd0);      // m1
7'd2:  inst_o <= sf_inst(OP_LOAD, 4'd2, 4'd0, 4'd0);      // m2
7'd3:  inst_o <= sf_inst(OP_LOAD, 4'd3, 4'd0, 4'd0);      // m3
7'd4:  inst_o <= sf_inst(OP_LOAD, 4'd4, 4'd0, 4'd0);      // m4
7'd5:  inst_o <= sf_inst(OP_LOAD, 4'd5, 4'd0, 4'd0);      // m5
// constant address is pc+1-DATA_LEN, so k1 arrives first and k0 wraps round last
7'd6:  inst_o <= sf_inst(OP_LOAD, 4'd7, 4'd0, 4'd0);      // k1
7'd7:  inst_o <= sf_inst(OP_LOAD, 4'd8, 4'd0, 4'd0);      // k2
7'd8:  inst_o <= sf_inst(OP_LOAD, 4'd9, 4'd0, 4'd0);      // k3
7'd9:  inst_o <= sf_inst(OP_LOAD, 4'd6, 4'd0, 4'd0);      // k0
// a = (m0*k0 + m1*k1) >>> 17
7'd10: inst_o <= sf_inst(OP_MUL, 4'd0, 4'd0, 4'd6);
7'd11: inst_o <= sf_inst(OP_MAC, 4'd0, 4'd1, 4'd7);
7'd12: inst_o <= sf_inst(OP_STORE, 4'd10, 4'd0, 4'd0);
// b = (m2*k2 + m3*k3) >>> 17
7'd13: inst_o <= sf_inst(OP_MUL, 4'd0, 4'd2, 4'd8);
7'd14: inst_o <= sf_inst(OP_MAC, 4'd0, 4'd3, 4'd9);
7'd15: inst_o <= sf_inst(OP_STORE, 4'd11, 4'd0, 4'd0);
// c = m4 + m5, d = m4 - m5, unscaled
7'd16: inst_o <= sf_inst(OP_ADD, 4'd0, 4'd4, 4'd5);
7'd17: inst_o <= sf_inst(OP_STORE_RAW, 4'd12, 4'd0, 4'd0);
7'd18: inst_o <= sf_inst(OP_SUB, 4'd0, 4'd4, 4'd5);
7'd19: inst_o <= sf_inst(OP_STORE_RAW, 4'd13, 4'd0, 4'd0);
// publish, clipping happens in the engine
7'd20: inst_o <= sf_inst(OP_OUT_AB, 4'd0, 4'd10, 4'd11);
7'd21: inst_o <= sf_inst(OP_OUT_CD, 4'd0, 4'd12, 4'd13);

//--- rtl/sf_pkg.sv
package sf_pkg;

	// port side widths
	localparam int PW         = 18;             // measurements, constants, results
	localparam int EXTRA      = 4;              // guard bits inside the engine
	localparam int REG_W      = PW + EXTRA;     // register file word
	localparam int ACC_W      = 2*PW + EXTRA;   // accumulator
	localparam int PROD_SHIFT = 17;             // scaling applied by OP_STORE

	// frame layout: measurements first, then the host constants
	localparam int DATA_LEN   = 6;
	localparam int CONSTS_LEN = 4;
	localparam int CONST_AW   = 2;

	// program counter, parks at the top value
	localparam int PC_W = 7;
	localparam logic [PC_W-1:0] PC_LAST = 7'd127;

	// instruction word {op, dest, srcA, srcB, spare}
	localparam int REG_AW   = 4;                // 16 registers
	localparam int OPC_W    = 5;
	localparam int INST_W   = 21;
	localparam int OP_LSB   = INST_W - OPC_W;   // 16
	localparam int DST_LSB  = OP_LSB - REG_AW;  // 12
	localparam int SRCA_LSB = DST_LSB - REG_AW; // 8
	localparam int SRCB_LSB = SRCA_LSB - REG_AW; // 4, low nibble spare

	// host bus
	localparam int WB_AW   = 3;
	localparam int SAT_ADR = CONSTS_LEN;        // saturation report sits after k3

	typedef enum logic [OPC_W-1:0] {
		OP_NOP,
		OP_LOAD,      // dest <= mux value
		OP_MUL,       // acc <= srcA * srcB
		OP_MAC,       // acc <= acc + srcA * srcB
		OP_ADD,       // acc <= srcA + srcB
		OP_SUB,       // acc <= srcA - srcB
		OP_STORE,     // dest <= acc >>> PROD_SHIFT
		OP_STORE_RAW, // dest <= acc
		OP_OUT_AB,    // publish srcA/srcB as a/b
		OP_OUT_CD     // publish srcA/srcB as c/d
	} sf_op_e;

	// packs one instruction word, spare bits stay zero
	function automatic logic [INST_W-1:0] sf_inst(
		input sf_op_e op,
		input logic [REG_AW-1:0] dst,
		input logic [REG_AW-1:0] sa,
		input logic [REG_AW-1:0] sb
	);
		logic [INST_W-1:0] w;
		w = '0;
		w[OP_LSB +: OPC_W]    = op;
		w[DST_LSB +: REG_AW]  = dst;
		w[SRCA_LSB +: REG_AW] = sa;
		w[SRCB_LSB +: REG_AW] = sb;
		return w;
	endfunction

endpackage

//--- rtl/sf_param_regs.sv
`timescale 1ns/1ps

module sf_param_regs
	import sf_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n_i,
	// wishbone classic slave
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [WB_AW-1:0]    wb_adr_i,
	input  logic [PW-1:0]       wb_dat_i,
	output logic [PW-1:0]       wb_dat_o,
	output logic                wb_ack_o,
	// sequencer side
	input  logic [CONST_AW-1:0] const_addr_i,
	output logic [PW-1:0]       const_data_o,
	input  logic [PC_W-1:0]     sat_report_i
);

	logic [PW-1:0] k [CONSTS_LEN];  // k0..k3
	logic          req;              // new access, not yet acked
	logic          is_const;         // address hits the constant bank
	logic          is_sat;

	assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign is_const = wb_adr_i < WB_AW'(CONSTS_LEN);
	assign is_sat   = wb_adr_i == WB_AW'(SAT_ADR);

	// single cycle ack, write lands on the ack edge
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_ack_o <= 1'b0;
			for (int i = 0; i < CONSTS_LEN; i++) begin
				k[i] <= '0;  // constants start at zero
			end
		end else begin
			wb_ack_o <= req;  // drops the cycle after, even if stb stays up
			if (req && wb_we_i && is_const) begin
				k[wb_adr_i[CONST_AW-1:0]] <= wb_dat_i;
			end
			// writes to the report address fall through here
		end
	end

	// readback decode, valid while ack is high since adr is held
	always_comb begin
		wb_dat_o = '0;  // unmapped addresses read zero
		if (is_const) begin
			wb_dat_o = k[wb_adr_i[CONST_AW-1:0]];
		end else if (is_sat) begin
			wb_dat_o = PW'(sat_report_i);  // zero extended count
		end
	end

	// asynchronous port into the sequencer mux
	assign const_data_o = k[const_addr_i];

endmodule

//--- rtl/sf_sequencer.sv
`timescale 1ns/1ps

module sf_sequencer
	import sf_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 ce_i,            // stalls everything here
	input  logic                 trigger_i,       // one ce cycle, ahead of the stream
	input  logic signed [PW-1:0] meas_i,
	output logic [CONST_AW-1:0]  const_addr_o,
	input  logic [PW-1:0]        const_data_i,
	input  logic [1:0]           sat_pulse_i,     // clips in the last engine step
	output logic [INST_W-1:0]    inst_o,
	output logic signed [PW-1:0] mux_o,
	output logic [PC_W-1:0]      sat_report_o,
	output logic [PC_W-1:0]      trace_addr_o,
	output logic                 trace_strobe_o
);

	logic [PC_W-1:0] pc;
	logic            step;          // low once parked
	logic            run;           // program active
	logic            run_d;         // one ce edge behind run
	logic            choose_const;
	logic [PC_W-1:0] sat_cnt;       // clips in the current frame

	assign step = pc != PC_LAST;

	// pc restarts on trigger and climbs to the park value
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc    <= PC_LAST;  // parked until the first trigger
			run   <= 1'b0;
			run_d <= 1'b0;
		end else if (ce_i) begin
			pc <= trigger_i ? '0 : pc + PC_W'(step);
			if (trigger_i) begin
				run <= 1'b1;
			end else if (!step) begin
				run <= 1'b0;
			end
			run_d <= run;
		end
	end

	assign trace_strobe_o = run_d;
	assign trace_addr_o   = pc;

	// stream order: DATA_LEN measurements then CONSTS_LEN constants
	assign choose_const = (pc >= PC_W'(DATA_LEN)) && (pc < PC_W'(DATA_LEN + CONSTS_LEN));
	assign const_addr_o = CONST_AW'(pc + 1 - DATA_LEN);  // wraps mod 4

	always_ff @(posedge clk) begin
		if (ce_i) begin
			mux_o <= choose_const ? $signed(const_data_i) : meas_i;
		end
	end

	// instruction rom, one registered word per pc value
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			inst_o <= '0;  // OP_NOP
		end else if (ce_i) begin
			if (trigger_i) begin
				inst_o <= '0;  // flush whatever the old frame was doing
			end else begin
				case (pc)
`include "sf_ops.svh"
					default: inst_o <= sf_inst(OP_NOP, 4'd0, 4'd0, 4'd0);
				endcase
			end
		end
	end

	// per frame saturation count, reported on the next trigger
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			sat_cnt      <= '0;
			sat_report_o <= '0;
		end else if (ce_i) begin
			sat_cnt <= trigger_i ? '0 : sat_cnt + PC_W'(sat_pulse_i);
			if (trigger_i) begin
				sat_report_o <= sat_cnt;  // previous frame
			end
		end
	end

endmodule

//--- rtl/sf_engine.sv
`timescale 1ns/1ps

module sf_engine
	import sf_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    ce_i,
	input  logic [INST_W-1:0]       inst_i,
	input  logic signed [PW-1:0]    mux_i,        // measurement or constant
	output logic                    ab_update_o,
	output logic signed [PW-1:0]    a_o,
	output logic signed [PW-1:0]    b_o,
	output logic                    cd_update_o,
	output logic signed [PW-1:0]    c_o,
	output logic signed [PW-1:0]    d_o,
	output logic signed [REG_W-1:0] trace_o,      // last register file write
	output logic [1:0]              sat_pulse_o   // clipped values this step
);

	sf_op_e                  op;
	logic [REG_AW-1:0]       dst;
	logic [REG_AW-1:0]       sa;
	logic [REG_AW-1:0]       sb;
	logic signed [REG_W-1:0] rf [2**REG_AW];
	logic signed [REG_W-1:0] ra;
	logic signed [REG_W-1:0] rb;
	logic signed [2*REG_W-1:0] prod_full;       // full 22x22 product
	logic signed [ACC_W-1:0] prod;
	logic signed [ACC_W-1:0] acc;
	logic                    wen;
	logic signed [REG_W-1:0] wdata;
	logic signed [PW-1:0]    sat_a;
	logic signed [PW-1:0]    sat_b;
	logic                    clip_a;
	logic                    clip_b;

	// clip one register to the port range, flag in the top bit
	function automatic logic [PW:0] sat_pw(input logic signed [REG_W-1:0] v);
		logic [EXTRA:0] hi;
		hi = v[REG_W-1:PW-1];  // guard bits plus port sign bit
		if (&hi || ~|hi) begin
			sat_pw = {1'b0, v[PW-1:0]};  // already in range
		end else if (v[REG_W-1]) begin
			sat_pw = {1'b1, 1'b1, {(PW-1){1'b0}}};  // -131072
		end else begin
			sat_pw = {1'b1, 1'b0, {(PW-1){1'b1}}};  // 131071
		end
	endfunction

	// field decode
	assign op  = sf_op_e'(inst_i[OP_LSB +: OPC_W]);
	assign dst = inst_i[DST_LSB +: REG_AW];
	assign sa  = inst_i[SRCA_LSB +: REG_AW];
	assign sb  = inst_i[SRCB_LSB +: REG_AW];

	assign ra = rf[sa];
	assign rb = rf[sb];

	assign prod_full = ra * rb;
	assign prod      = ACC_W'(prod_full);  // operands are 18 bit values, no loss

	assign {clip_a, sat_a} = sat_pw(ra);
	assign {clip_b, sat_b} = sat_pw(rb);

	// register file write port
	always_comb begin
		wen   = 1'b0;
		wdata = '0;
		case (op)
			OP_LOAD: begin
				wen   = 1'b1;
				wdata = REG_W'(mux_i);  // sign extend into the guard bits
			end
			OP_STORE: begin
				wen   = 1'b1;
				wdata = REG_W'(acc >>> PROD_SHIFT);
			end
			OP_STORE_RAW: begin
				wen   = 1'b1;
				wdata = REG_W'(acc);
			end
			default: ;
		endcase
	end

	// register file and accumulator hold payload only
	always_ff @(posedge clk) begin
		if (ce_i) begin
			if (wen) begin
				rf[dst] <= wdata;
			end
			case (op)
				OP_MUL: acc <= prod;
				OP_MAC: acc <= acc + prod;
				OP_ADD: acc <= ACC_W'(ra) + ACC_W'(rb);
				OP_SUB: acc <= ACC_W'(ra) - ACC_W'(rb);
				default: ;  // acc holds
			endcase
		end
	end

	// published results, update flags last one ce cycle
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			a_o         <= '0;
			b_o         <= '0;
			c_o         <= '0;
			d_o         <= '0;
			ab_update_o <= 1'b0;
			cd_update_o <= 1'b0;
			sat_pulse_o <= '0;
			trace_o     <= '0;
		end else if (ce_i) begin
			ab_update_o <= op == OP_OUT_AB;
			cd_update_o <= op == OP_OUT_CD;
			sat_pulse_o <= '0;
			if (op == OP_OUT_AB) begin
				a_o         <= sat_a;
				b_o         <= sat_b;
				sat_pulse_o <= 2'(clip_a) + 2'(clip_b);
			end
			if (op == OP_OUT_CD) begin
				c_o         <= sat_a;
				d_o         <= sat_b;
				sat_pulse_o <= 2'(clip_a) + 2'(clip_b);
			end
			if (wen) begin
				trace_o <= wdata;  // mirrors the write
			end
		end
	end

endmodule

//--- rtl/sf_top.sv
`timescale 1ns/1ps

module sf_top
	import sf_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    ce_i,
	input  logic                    trigger_i,
	input  logic signed [PW-1:0]    meas_i,
	// host bus
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  logic [WB_AW-1:0]        wb_adr_i,
	input  logic [PW-1:0]           wb_dat_i,
	output logic [PW-1:0]           wb_dat_o,
	output logic                    wb_ack_o,
	// results
	output logic                    ab_update_o,
	output logic signed [PW-1:0]    a_o,
	output logic signed [PW-1:0]    b_o,
	output logic                    cd_update_o,
	output logic signed [PW-1:0]    c_o,
	output logic signed [PW-1:0]    d_o,
	// debug
	output logic signed [REG_W-1:0] trace_o,
	output logic [PC_W-1:0]         trace_addr_o,
	output logic                    trace_strobe_o
);

	logic [CONST_AW-1:0]  const_addr;
	logic [PW-1:0]        const_data;
	logic [PC_W-1:0]      sat_report;
	logic [INST_W-1:0]    inst;
	logic signed [PW-1:0] mux;
	logic [1:0]           sat_pulse;

	// host constants and status readback
	sf_param_regs u_regs (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.const_addr_i (const_addr),
		.const_data_o (const_data),
		.sat_report_i (sat_report)
	);

	sf_sequencer u_seq (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.ce_i           (ce_i),
		.trigger_i      (trigger_i),
		.meas_i         (meas_i),
		.const_addr_o   (const_addr),
		.const_data_i   (const_data),
		.sat_pulse_i    (sat_pulse),
		.inst_o         (inst),
		.mux_o          (mux),
		.sat_report_o   (sat_report),
		.trace_addr_o   (trace_addr_o),
		.trace_strobe_o (trace_strobe_o)
	);

	sf_engine u_eng (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ce_i        (ce_i),
		.inst_i      (inst),
		.mux_i       (mux),
		.ab_update_o (ab_update_o),
		.a_o         (a_o),
		.b_o         (b_o),
		.cd_update_o (cd_update_o),
		.c_o         (c_o),
		.d_o         (d_o),
		.trace_o     (trace_o),
		.sat_pulse_o (sat_pulse)
	);

endmodule

//--- verification/sf_properties.sv
`timescale 1ns/1ps

module sf_properties
	import sf_pkg::*;
(
	input logic            clk,
	input logic            rst_n_i,
	input logic            ce_i,
	input logic            wb_cyc_i,
	input logic            wb_stb_i,
	input logic            wb_ack_o,
	input logic            ab_update_o,
	input logic            cd_update_o,
	input logic [PC_W-1:0] trace_addr_o,
	input logic            trace_strobe_o
);

	int fail_cnt = 0;  // failed assertions so far

	// ack answers a live request and never stretches
	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_o |-> wb_cyc_i && wb_stb_i)
		else begin
			fail_cnt++;
			$error("wb_ack_o high outside cyc and stb");
		end
	ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_o |=> !wb_ack_o)
		else begin
			fail_cnt++;
			$error("wb_ack_o high for two cycles in a row");
		end

	// updates last one ce cycle
	ab_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		ab_update_o && ce_i |=> !ab_update_o)
		else begin
			fail_cnt++;
			$error("ab_update_o held over a ce edge");
		end
	cd_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		cd_update_o && ce_i |=> !cd_update_o)
		else begin
			fail_cnt++;
			$error("cd_update_o held over a ce edge");
		end

	// once parked and quiet, strobe stays low
	strobe_parked: assert property (@(posedge clk) disable iff (!rst_n_i)
		!trace_strobe_o && trace_addr_o == PC_LAST |=> !trace_strobe_o)
		else begin
			fail_cnt++;
			$error("trace_strobe_o came back while parked");
		end

endmodule

bind sf_top sf_properties u_props (
	.clk            (clk),
	.rst_n_i        (rst_n_i),
	.ce_i           (ce_i),
	.wb_cyc_i       (wb_cyc_i),
	.wb_stb_i       (wb_stb_i),
	.wb_ack_o       (wb_ack_o),
	.ab_update_o    (ab_update_o),
	.cd_update_o    (cd_update_o),
	.trace_addr_o   (trace_addr_o),
	.trace_strobe_o (trace_strobe_o)
);

//--- verification/sf_tb.sv
`timescale 1ns/1ps

module sf_tb
	import sf_pkg::*;
();

	localparam int NROWS   = 6;
	localparam int TIMEOUT = 1000;  // clock cycles per wait loop

	logic clk, rst_n_i, ce_i, trigger_i;
	logic wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic ab_update_o, cd_update_o, trace_strobe_o;
	logic [WB_AW-1:0] wb_adr_i;
	logic [PW-1:0] wb_dat_i, wb_dat_o;
	logic signed [PW-1:0] meas_i, a_o, b_o, c_o, d_o;
	logic signed [REG_W-1:0] trace_o;
	logic [PC_W-1:0] trace_addr_o;

	// frame table with expected columns filled from the m and k columns
	logic signed [PW-1:0] row_m   [NROWS][DATA_LEN];
	logic signed [PW-1:0] row_k   [NROWS][CONSTS_LEN];
	logic signed [PW-1:0] exp_res [NROWS][4];  // a b c d
	logic signed [REG_W-1:0] exp_trace [NROWS];  // last register write is the raw d
	int row_sel [NROWS];                        // 0 ce high, 1 about half, 2 one in four
	int exp_sat [NROWS];

	int   seed = 29;
	int   errors = 0;
	int   checks = 0;
	int   ab_total = 0;  // rising edges seen by the monitor
	int   cd_total = 0;
	int   early_ab = 0;  // ab pulses with no frame running
	logic armed = 1'b0;
	logic ab_prev = 1'b0;
	logic cd_prev = 1'b0;

	sf_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// update edges sampled away from the active edge
	always @(negedge clk) begin
		if (ab_update_o && !ab_prev) begin
			ab_total++;
			if (!armed) begin
				early_ab++;
				$display("ab_update_o pulsed while no frame was running");
			end
		end
		if (cd_update_o && !cd_prev) begin
			cd_total++;
		end
		ab_prev = ab_update_o;
		cd_prev = cd_update_o;
	end

	function automatic logic pick_ce(input int sel);
		int r;
		r = $random(seed);
		case (sel)
			1: return r[0];
			2: return r[1:0] == 2'b00;  // sparse gaps
			default: return 1'b1;
		endcase
	endfunction

	function automatic longint rand18();
		int r;
		r = $random(seed);
		return longint'($signed(r[PW-1:0]));
	endfunction

	// result range of the ports is -131072 .. 131071
	function automatic longint clip18(input longint v);
		if (v > 131071) return 131071;
		if (v < -131072) return -131072;
		return v;
	endfunction

	task automatic set_row(input int r, input int sel, input longint m0, m1, m2, m3, m4, m5,
			input longint k0, k1, k2, k3);
		longint m [DATA_LEN];
		longint k [CONSTS_LEN];
		longint res [4];
		m = '{m0, m1, m2, m3, m4, m5};
		k = '{k0, k1, k2, k3};
		row_sel[r] = sel;
		for (int i = 0; i < DATA_LEN; i++) row_m[r][i] = PW'(m[i]);
		for (int i = 0; i < CONSTS_LEN; i++) row_k[r][i] = PW'(k[i]);
		res[0] = (m0 * k0 + m1 * k1) >>> PROD_SHIFT;
		res[1] = (m2 * k2 + m3 * k3) >>> PROD_SHIFT;
		res[2] = m4 + m5;
		res[3] = m4 - m5;
		exp_trace[r] = REG_W'(res[3]);  // d before clipping
		exp_sat[r] = 0;
		for (int i = 0; i < 4; i++) begin
			if (clip18(res[i]) != res[i]) exp_sat[r]++;  // one count per clipped result
			exp_res[r][i] = PW'(clip18(res[i]));
		end
	endtask

	task automatic check_value(input string name, input logic [PW-1:0] got,
			input logic [PW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %05h expected %05h", name, got, exp);
		end
	endtask

	// one classic cycle closed on the edge that sees ack
	task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
			input logic [PW-1:0] wdat, output logic [PW-1:0] rdat);
		int n;
		n = 0;
		ce_i     = 1'b0;  // datapath holds still meanwhile
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		@(negedge clk);
		while (!wb_ack_o && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack_o) begin
			errors++;
			$display("no wishbone acknowledge for address %0d", adr);
		end
		rdat = wb_dat_o;  // adr still held here
		@(negedge clk);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	// holds the present inputs until a ce-high edge takes them
	task automatic consume(input int sel);
		int n;
		n = 0;
		ce_i = 1'b0;
		while (!ce_i && n < TIMEOUT) begin
			ce_i = pick_ce(sel);
			@(negedge clk);
			n++;
		end
		if (!ce_i) begin
			errors++;
			$display("no clock enable edge took the input in time");
		end
	endtask

	task automatic pulse_trigger(input int sel);
		trigger_i = 1'b1;
		consume(sel);
		trigger_i = 1'b0;
	endtask

	task automatic run_frame(input int r, input int prev_sat);
		logic [PW-1:0] rd;
		int            n;
		int            ab0;
		int            cd0;
		for (int i = 0; i < CONSTS_LEN; i++) wb_access(1'b1, WB_AW'(i), row_k[r][i], rd);
		for (int i = 0; i < CONSTS_LEN; i++) begin
			wb_access(1'b0, WB_AW'(i), '0, rd);
			check_value($sformatf("wb_dat_o[k%0d]", i), rd, row_k[r][i]);
		end
		ab0 = ab_total;
		cd0 = cd_total;
		pulse_trigger(row_sel[r]);
		armed = 1'b1;
		wb_access(1'b0, WB_AW'(SAT_ADR), '0, rd);  // count of the frame before
		check_value("wb_dat_o[sat]", rd, PW'(prev_sat));
		for (int i = 0; i < DATA_LEN; i++) begin
			meas_i = row_m[r][i];
			consume(row_sel[r]);
		end
		n = 0;
		while (cd_total == cd0 && n < TIMEOUT) begin
			ce_i = pick_ce(row_sel[r]);
			@(negedge clk);
			n++;
		end
		if (cd_total == cd0) begin
			errors++;
			$display("cd_update_o never pulsed in frame %0d", r);
		end
		// run on to the park value so the last clip is counted
		n = 0;
		ce_i = 1'b1;
		while (trace_addr_o != PC_LAST && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (trace_addr_o != PC_LAST) begin
			errors++;
			$display("program counter did not park in frame %0d", r);
		end
		check_value("a_o", a_o, exp_res[r][0]);
		check_value("b_o", b_o, exp_res[r][1]);
		check_value("c_o", c_o, exp_res[r][2]);
		check_value("d_o", d_o, exp_res[r][3]);
		checks++;
		if (trace_o !== exp_trace[r]) begin
			errors++;
			$display("ERR trace_o got %06h expected %06h", trace_o, exp_trace[r]);
		end
		check_value("ab_update_o pulses", PW'(ab_total - ab0), PW'(1));
		check_value("cd_update_o pulses", PW'(cd_total - cd0), PW'(1));
		armed = 1'b0;
	endtask

	initial begin
		logic [PW-1:0] rd;
		int            total;
		rst_n_i   = 1'b0;
		ce_i      = 1'b0;
		trigger_i = 1'b0;
		meas_i    = '0;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		set_row(0, 0, 1000, -2000, 30000, -40000, 500, 700, 65536, 131071, -50000, 12345);
		set_row(1, 1, 1000, -2000, 30000, -40000, 500, 700, 65536, 131071, -50000, 12345);
		set_row(2, 2, 131071, 131071, -131072, -131072, 131071, 131071,
			131071, 131071, 131071, 131071);  // a high, b low, c high
		set_row(3, 1, -5, 7, 100, 100, -100000, 100000, -131072, -131072, 1000, -1000);
		set_row(4, 2, rand18(), rand18(), rand18(), rand18(), rand18(), rand18(),
			rand18(), rand18(), rand18(), rand18());
		set_row(5, 0, rand18(), rand18(), rand18(), rand18(), rand18(), rand18(),
			rand18(), rand18(), rand18(), rand18());
		repeat (2) @(negedge clk);
		rst_n_i = 1'b1;
		check_value("trace_addr_o", PW'(trace_addr_o), PW'(PC_LAST));
		check_value("{ab_update_o,cd_update_o,trace_strobe_o,wb_ack_o}",
			PW'({ab_update_o, cd_update_o, trace_strobe_o, wb_ack_o}), '0);
		check_value("a_o", a_o, '0);
		check_value("b_o", b_o, '0);
		check_value("c_o", c_o, '0);
		check_value("d_o", d_o, '0);
		wb_access(1'b1, 3'd0, 18'h01234, rd);
		wb_access(1'b1, WB_AW'(SAT_ADR), 18'h2aaaa, rd);  // report is read only
		wb_access(1'b0, WB_AW'(SAT_ADR), '0, rd);
		check_value("wb_dat_o[sat]", rd, '0);
		wb_access(1'b0, 3'd0, '0, rd);  // k0 untouched by the report write
		check_value("wb_dat_o[k0]", rd, 18'h01234);
		wb_access(1'b0, 3'd6, '0, rd);
		check_value("wb_dat_o[6]", rd, '0);
		for (int r = 0; r < NROWS; r++) run_frame(r, (r == 0) ? 0 : exp_sat[r-1]);
		pulse_trigger(0);  // latches the last frame's count
		wb_access(1'b0, WB_AW'(SAT_ADR), '0, rd);
		check_value("wb_dat_o[sat]", rd, PW'(exp_sat[NROWS-1]));
		total = errors + early_ab + dut.u_props.fail_cnt;
		$display("checks %0d, errors %0d, early pulses %0d, assertion failures %0d",
			checks, errors, early_ab, dut.u_props.fail_cnt);
		if (total == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+rtl
rtl/sf_pkg.sv
rtl/sf_param_regs.sv
rtl/sf_sequencer.sv
rtl/sf_engine.sv
rtl/sf_top.sv
verification/sf_properties.sv
verification/sf_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sf_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
